/* pipeline_cfg.svh */
`ifndef PIPELINE_CFG_SVH
`define PIPELINE_CFG_SVH

// RV32I data word
`define PIPE_XLEN 32

// x0..x31
`define PIPE_REG_AW 5

// csr address space
`define PIPE_CSR_AW 12

`endif

/* pipeline_pkg.sv */
package pipeline_pkg;

    // RV32I major opcodes from instruction bits [6:0]
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_OP_IMM   = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP_OP       = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011
    } opcode_e;

    // reason handed to the trap handler
    typedef enum logic [2:0] {
        TRAP_NONE         = 3'd0,
        TRAP_ID_EXCEPTION = 3'd1, // decode stage exception puts the pipeline in standby
        TRAP_ECALL        = 3'd2,
        TRAP_MISALIGNED   = 3'd3,
        TRAP_INTERRUPT    = 3'd4
    } trap_cause_e;

    // trap handshake states
    typedef enum logic [1:0] {
        TS_IDLE    = 2'b00,
        TS_REQ     = 2'b01, // req high until ack
        TS_RELEASE = 2'b10, // req low until ack drops
        TS_FLUSH   = 2'b11  // single cycle flush of all stages
    } trap_state_e;

endpackage

/* hazard_unit.sv */
`include "pipeline_cfg.svh"

module hazard_unit (
    input  logic                        trap_done,
    input  logic                        csr_ready,
    input  logic                        standby_mode,
    input  logic                        pth_done_flush,

    input  logic [`PIPE_REG_AW-1:0]     id_rs1,
    input  logic [`PIPE_REG_AW-1:0]     id_rs2,

    input  logic [`PIPE_REG_AW-1:0]     ex_rd,
    input  logic [`PIPE_REG_AW-1:0]     ex_rs1,
    input  logic [`PIPE_REG_AW-1:0]     ex_rs2,
    input  pipeline_pkg::opcode_e       ex_opcode,
    input  logic [`PIPE_CSR_AW-1:0]     ex_csr_addr,
    input  logic                        ex_jump,
    input  logic                        branch_miss,

    input  logic [`PIPE_REG_AW-1:0]     mem_rd,
    input  logic                        mem_reg_we,
    input  logic                        mem_csr_we,
    input  logic [`PIPE_CSR_AW-1:0]     mem_csr_addr,

    input  logic [`PIPE_REG_AW-1:0]     wb_rd,
    input  logic                        wb_reg_we,
    input  logic                        wb_csr_we,
    input  logic [`PIPE_CSR_AW-1:0]     wb_csr_addr,

    output logic [1:0]                  hazard_mem, // bit 0 rs1, bit 1 rs2
    output logic [1:0]                  hazard_wb,
    output logic                        csr_hazard_mem,
    output logic                        csr_hazard_wb,

    output logic                        if_id_flush,
    output logic                        id_ex_flush,
    output logic                        ex_mem_flush,
    output logic                        mem_wb_flush,

    output logic                        if_id_stall,
    output logic                        id_ex_stall,
    output logic                        ex_mem_stall,
    output logic                        mem_wb_stall
);

    logic load_use;
    logic mem_wr_valid;
    logic wb_wr_valid;
    logic [1:0] mem_match;
    logic [1:0] wb_match;

    // load in EX feeding the instruction in ID
    assign load_use = (ex_opcode == pipeline_pkg::OP_LOAD) && (ex_rd != '0) &&
                      ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    assign mem_wr_valid = mem_reg_we && (mem_rd != '0); // x0 never forwards
    assign wb_wr_valid  = wb_reg_we && (wb_rd != '0);

    assign mem_match = {mem_wr_valid && (mem_rd == ex_rs2), mem_wr_valid && (mem_rd == ex_rs1)};
    assign wb_match  = {wb_wr_valid && (wb_rd == ex_rs2), wb_wr_valid && (wb_rd == ex_rs1)};

    // MEM is younger, so it wins
    assign hazard_mem = mem_match;
    assign hazard_wb  = wb_match & ~mem_match;

    assign csr_hazard_mem = mem_csr_we && (mem_csr_addr == ex_csr_addr);
    assign csr_hazard_wb  = wb_csr_we && (wb_csr_addr == ex_csr_addr);

    always_comb begin
        if_id_flush  = 1'b0;
        id_ex_flush  = 1'b0;
        ex_mem_flush = 1'b0;
        mem_wb_flush = 1'b0;
        if_id_stall  = 1'b0;
        id_ex_stall  = 1'b0;
        ex_mem_stall = 1'b0;
        mem_wb_stall = 1'b0;

        if (load_use) begin
            {if_id_stall, id_ex_stall, ex_mem_stall, mem_wb_stall} = 4'b1111;
            id_ex_flush = 1'b1; // bubble into EX
        end

        // redirect only counts when no trap owns the pipe
        if (trap_done && (ex_jump || branch_miss)) begin
            if_id_flush = 1'b1;
            id_ex_flush = 1'b1;
        end

        if (pth_done_flush) begin
            {if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush} = 4'b1111;
        end

        // standby lets the back end drain
        if (standby_mode) begin
            {if_id_stall, id_ex_stall, ex_mem_stall, mem_wb_stall} = 4'b1100;
        end else if (!trap_done || !csr_ready) begin
            {if_id_stall, id_ex_stall, ex_mem_stall, mem_wb_stall} = 4'b1111;
        end
    end

endmodule

/* forward_unit.sv */
`include "pipeline_cfg.svh"

module forward_unit (
    input  logic [1:0]              hazard_mem, // bit 0 rs1, bit 1 rs2
    input  logic [1:0]              hazard_wb,
    input  logic                    csr_hazard_mem,
    input  logic                    csr_hazard_wb,

    input  logic [`PIPE_XLEN-1:0]   rf_rs1_data,
    input  logic [`PIPE_XLEN-1:0]   rf_rs2_data,
    input  logic [`PIPE_XLEN-1:0]   csr_read_data,

    input  logic [`PIPE_XLEN-1:0]   mem_alu_result,
    input  logic [`PIPE_XLEN-1:0]   wb_write_data,
    input  logic [`PIPE_XLEN-1:0]   mem_csr_wdata,
    input  logic [`PIPE_XLEN-1:0]   wb_csr_wdata,

    output logic [`PIPE_XLEN-1:0]   ex_op1,
    output logic [`PIPE_XLEN-1:0]   ex_op2,
    output logic [`PIPE_XLEN-1:0]   ex_csr_op
);

    // MEM first, then WB, then the stored value
    function automatic logic [`PIPE_XLEN-1:0] pick(
        input logic                  sel_mem,
        input logic                  sel_wb,
        input logic [`PIPE_XLEN-1:0] mem_val,
        input logic [`PIPE_XLEN-1:0] wb_val,
        input logic [`PIPE_XLEN-1:0] file_val
    );
        logic [`PIPE_XLEN-1:0] result;
        if (sel_mem) begin
            result = mem_val;
        end else if (sel_wb) begin
            result = wb_val;
        end else begin
            result = file_val;
        end
        return result;
    endfunction

    always_comb begin
        ex_op1 = pick(hazard_mem[0], hazard_wb[0],
                      mem_alu_result, wb_write_data, rf_rs1_data);
        ex_op2 = pick(hazard_mem[1], hazard_wb[1],
                      mem_alu_result, wb_write_data, rf_rs2_data);

        // csr path uses the pending csr write data
        ex_csr_op = pick(csr_hazard_mem, csr_hazard_wb,
                         mem_csr_wdata, wb_csr_wdata, csr_read_data);
    end

endmodule

/* trap_sequencer.sv */
module trap_sequencer (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        trap_valid,
    input  pipeline_pkg::trap_cause_e   trap_cause,
    input  logic                        trap_ack,

    output logic                        trap_req,
    output pipeline_pkg::trap_cause_e   trap_cause_out,
    output logic                        trap_done,
    output logic                        standby_mode,
    output logic                        pth_done_flush
);

    pipeline_pkg::trap_state_e state;
    pipeline_pkg::trap_state_e state_next;
    pipeline_pkg::trap_cause_e cause_q;

    always_comb begin
        state_next = state;
        case (state)
            pipeline_pkg::TS_IDLE: begin
                if (trap_valid) begin
                    state_next = pipeline_pkg::TS_REQ;
                end
            end
            pipeline_pkg::TS_REQ: begin
                if (trap_ack) begin
                    state_next = pipeline_pkg::TS_RELEASE; // drop req
                end
            end
            pipeline_pkg::TS_RELEASE: begin
                if (!trap_ack) begin
                    state_next = pipeline_pkg::TS_FLUSH; // handler done
                end
            end
            pipeline_pkg::TS_FLUSH: begin
                state_next = pipeline_pkg::TS_IDLE;
            end
            default: begin
                state_next = pipeline_pkg::TS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= pipeline_pkg::TS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // cause is captured on acceptance and held for the whole handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cause_q <= pipeline_pkg::TRAP_NONE;
        end else if (state == pipeline_pkg::TS_IDLE && trap_valid) begin
            cause_q <= trap_cause;
        end
    end

    assign trap_req       = (state == pipeline_pkg::TS_REQ);
    assign trap_cause_out = cause_q;
    assign trap_done      = (state == pipeline_pkg::TS_IDLE);
    assign pth_done_flush = (state == pipeline_pkg::TS_FLUSH);

    // decode exception keeps the back end running
    assign standby_mode = (state != pipeline_pkg::TS_IDLE) &&
                          (cause_q == pipeline_pkg::TRAP_ID_EXCEPTION);

endmodule

/* pipeline_control.sv */
`include "pipeline_cfg.svh"

module pipeline_control (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        csr_ready,
    input  logic [`PIPE_REG_AW-1:0]     id_rs1,
    input  logic [`PIPE_REG_AW-1:0]     id_rs2,

    input  logic [`PIPE_REG_AW-1:0]     ex_rd,
    input  logic [`PIPE_REG_AW-1:0]     ex_rs1,
    input  logic [`PIPE_REG_AW-1:0]     ex_rs2,
    input  pipeline_pkg::opcode_e       ex_opcode,
    input  logic [`PIPE_CSR_AW-1:0]     ex_csr_addr,
    input  logic                        ex_jump,
    input  logic                        branch_miss,

    input  logic [`PIPE_REG_AW-1:0]     mem_rd,
    input  logic                        mem_reg_we,
    input  logic                        mem_csr_we,
    input  logic [`PIPE_CSR_AW-1:0]     mem_csr_addr,

    input  logic [`PIPE_REG_AW-1:0]     wb_rd,
    input  logic                        wb_reg_we,
    input  logic                        wb_csr_we,
    input  logic [`PIPE_CSR_AW-1:0]     wb_csr_addr,

    input  logic [`PIPE_XLEN-1:0]       rf_rs1_data,
    input  logic [`PIPE_XLEN-1:0]       rf_rs2_data,
    input  logic [`PIPE_XLEN-1:0]       csr_read_data,
    input  logic [`PIPE_XLEN-1:0]       mem_alu_result,
    input  logic [`PIPE_XLEN-1:0]       wb_write_data,
    input  logic [`PIPE_XLEN-1:0]       mem_csr_wdata,
    input  logic [`PIPE_XLEN-1:0]       wb_csr_wdata,

    input  logic                        trap_valid,
    input  pipeline_pkg::trap_cause_e   trap_cause,
    input  logic                        trap_ack,

    output logic [`PIPE_XLEN-1:0]       ex_op1,
    output logic [`PIPE_XLEN-1:0]       ex_op2,
    output logic [`PIPE_XLEN-1:0]       ex_csr_op,

    output logic [1:0]                  hazard_mem,
    output logic [1:0]                  hazard_wb,
    output logic                        csr_hazard_mem,
    output logic                        csr_hazard_wb,

    output logic                        if_id_flush,
    output logic                        id_ex_flush,
    output logic                        ex_mem_flush,
    output logic                        mem_wb_flush,
    output logic                        if_id_stall,
    output logic                        id_ex_stall,
    output logic                        ex_mem_stall,
    output logic                        mem_wb_stall,

    output logic                        trap_req,
    output pipeline_pkg::trap_cause_e   trap_cause_out,
    output logic                        trap_done,
    output logic                        standby_mode,
    output logic                        pth_done_flush
);

    hazard_unit u_hazard (
        .trap_done      (trap_done),
        .csr_ready      (csr_ready),
        .standby_mode   (standby_mode),
        .pth_done_flush (pth_done_flush),
        .id_rs1         (id_rs1),
        .id_rs2         (id_rs2),
        .ex_rd          (ex_rd),
        .ex_rs1         (ex_rs1),
        .ex_rs2         (ex_rs2),
        .ex_opcode      (ex_opcode),
        .ex_csr_addr    (ex_csr_addr),
        .ex_jump        (ex_jump),
        .branch_miss    (branch_miss),
        .mem_rd         (mem_rd),
        .mem_reg_we     (mem_reg_we),
        .mem_csr_we     (mem_csr_we),
        .mem_csr_addr   (mem_csr_addr),
        .wb_rd          (wb_rd),
        .wb_reg_we      (wb_reg_we),
        .wb_csr_we      (wb_csr_we),
        .wb_csr_addr    (wb_csr_addr),
        .hazard_mem     (hazard_mem),
        .hazard_wb      (hazard_wb),
        .csr_hazard_mem (csr_hazard_mem),
        .csr_hazard_wb  (csr_hazard_wb),
        .if_id_flush    (if_id_flush),
        .id_ex_flush    (id_ex_flush),
        .ex_mem_flush   (ex_mem_flush),
        .mem_wb_flush   (mem_wb_flush),
        .if_id_stall    (if_id_stall),
        .id_ex_stall    (id_ex_stall),
        .ex_mem_stall   (ex_mem_stall),
        .mem_wb_stall   (mem_wb_stall)
    );

    // selects come straight from the hazard unit
    forward_unit u_forward (
        .hazard_mem     (hazard_mem),
        .hazard_wb      (hazard_wb),
        .csr_hazard_mem (csr_hazard_mem),
        .csr_hazard_wb  (csr_hazard_wb),
        .rf_rs1_data    (rf_rs1_data),
        .rf_rs2_data    (rf_rs2_data),
        .csr_read_data  (csr_read_data),
        .mem_alu_result (mem_alu_result),
        .wb_write_data  (wb_write_data),
        .mem_csr_wdata  (mem_csr_wdata),
        .wb_csr_wdata   (wb_csr_wdata),
        .ex_op1         (ex_op1),
        .ex_op2         (ex_op2),
        .ex_csr_op      (ex_csr_op)
    );

    trap_sequencer u_trap (
        .clk            (clk),
        .reset          (reset),
        .trap_valid     (trap_valid),
        .trap_cause     (trap_cause),
        .trap_ack       (trap_ack),
        .trap_req       (trap_req),
        .trap_cause_out (trap_cause_out),
        .trap_done      (trap_done),
        .standby_mode   (standby_mode),
        .pth_done_flush (pth_done_flush)
    );

endmodule

/* hazard_checker.sv */
`include "pipeline_cfg.svh"

module hazard_checker (
    input  logic                      clk, reset, csr_ready, ex_jump, branch_miss,
    input  logic                      mem_reg_we, mem_csr_we, wb_reg_we, wb_csr_we,
    input  logic                      trap_valid, trap_ack,
    input  logic [`PIPE_REG_AW-1:0]   id_rs1, id_rs2, ex_rd, ex_rs1, ex_rs2, mem_rd, wb_rd,
    input  logic [`PIPE_CSR_AW-1:0]   ex_csr_addr, mem_csr_addr, wb_csr_addr,
    input  pipeline_pkg::opcode_e     ex_opcode,
    input  pipeline_pkg::trap_cause_e trap_cause, trap_cause_out,
    input  logic [`PIPE_XLEN-1:0]     rf_rs1_data, rf_rs2_data, csr_read_data, mem_alu_result,
    input  logic [`PIPE_XLEN-1:0]     wb_write_data, mem_csr_wdata, wb_csr_wdata,
    input  logic [`PIPE_XLEN-1:0]     ex_op1, ex_op2, ex_csr_op,
    input  logic [1:0]                hazard_mem, hazard_wb,
    input  logic                      csr_hazard_mem, csr_hazard_wb, trap_req, trap_done,
    input  logic                      standby_mode, pth_done_flush,
    input  logic                      if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush,
    input  logic                      if_id_stall, id_ex_stall, ex_mem_stall, mem_wb_stall,
    output int                        errors,
    output int                        checks
);

    pipeline_pkg::trap_state_e st; // mirror of the sequencer
    pipeline_pkg::trap_cause_e cause;

    // x0 and disabled writes never forward
    wire mem_ok = mem_reg_we && (mem_rd != 0);
    wire wb_ok = wb_reg_we && (wb_rd != 0);
    wire [1:0] fwd_mem = {mem_ok && (mem_rd == ex_rs2), mem_ok && (mem_rd == ex_rs1)};
    wire [1:0] fwd_wb = {wb_ok && (wb_rd == ex_rs2), wb_ok && (wb_rd == ex_rs1)} & ~fwd_mem;
    wire csr_mem = mem_csr_we && (mem_csr_addr == ex_csr_addr);
    wire csr_wb = wb_csr_we && (wb_csr_addr == ex_csr_addr);

    wire [`PIPE_XLEN-1:0] exp_op1 = fwd_mem[0] ? mem_alu_result :
                                    fwd_wb[0] ? wb_write_data : rf_rs1_data;
    wire [`PIPE_XLEN-1:0] exp_op2 = fwd_mem[1] ? mem_alu_result :
                                    fwd_wb[1] ? wb_write_data : rf_rs2_data;
    wire [`PIPE_XLEN-1:0] exp_csr = csr_mem ? mem_csr_wdata :
                                    csr_wb ? wb_csr_wdata : csr_read_data;

    wire idle = (st == pipeline_pkg::TS_IDLE);
    wire standby = !idle && (cause == pipeline_pkg::TRAP_ID_EXCEPTION);
    wire flush_all = (st == pipeline_pkg::TS_FLUSH);
    wire load_use = (ex_opcode == pipeline_pkg::OP_LOAD) && (ex_rd != 0) &&
                    ((ex_rd == id_rs1) || (ex_rd == id_rs2));
    wire redirect = idle && (ex_jump || branch_miss);

    // order is if_id, id_ex, ex_mem, mem_wb
    wire [3:0] exp_stall = standby ? 4'b1100 :
                           (!idle || !csr_ready || load_use) ? 4'b1111 : 4'b0000;
    wire [3:0] exp_flush = flush_all ? 4'b1111 : {redirect, redirect || load_use, 2'b00};

    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            st = pipeline_pkg::TS_IDLE;
            cause = pipeline_pkg::TRAP_NONE;
        end else begin
            case (st)
                pipeline_pkg::TS_IDLE: begin
                    if (trap_valid) begin
                        cause = trap_cause; // latched on acceptance
                        st = pipeline_pkg::TS_REQ;
                    end
                end
                pipeline_pkg::TS_REQ: st = trap_ack ? pipeline_pkg::TS_RELEASE : st;
                pipeline_pkg::TS_RELEASE: st = trap_ack ? st : pipeline_pkg::TS_FLUSH;
                default: st = pipeline_pkg::TS_IDLE;
            endcase
        end
    end

    always @(posedge clk) begin
        #5; // sequencer outputs settle after the edge
        if (!reset) begin
            compare("hazard_mem", 32'(fwd_mem), 32'(hazard_mem));
            compare("hazard_wb", 32'(fwd_wb), 32'(hazard_wb));
            compare("csr_hazard_mem", 32'(csr_mem), 32'(csr_hazard_mem));
            compare("csr_hazard_wb", 32'(csr_wb), 32'(csr_hazard_wb));
            compare("ex_op1", exp_op1, ex_op1);
            compare("ex_op2", exp_op2, ex_op2);
            compare("ex_csr_op", exp_csr, ex_csr_op);
            compare("if_id_stall", 32'(exp_stall[3]), 32'(if_id_stall));
            compare("id_ex_stall", 32'(exp_stall[2]), 32'(id_ex_stall));
            compare("ex_mem_stall", 32'(exp_stall[1]), 32'(ex_mem_stall));
            compare("mem_wb_stall", 32'(exp_stall[0]), 32'(mem_wb_stall));
            compare("if_id_flush", 32'(exp_flush[3]), 32'(if_id_flush));
            compare("id_ex_flush", 32'(exp_flush[2]), 32'(id_ex_flush));
            compare("ex_mem_flush", 32'(exp_flush[1]), 32'(ex_mem_flush));
            compare("mem_wb_flush", 32'(exp_flush[0]), 32'(mem_wb_flush));
            compare("trap_req", 32'(st == pipeline_pkg::TS_REQ), 32'(trap_req));
            compare("trap_cause_out", 32'(cause), 32'(trap_cause_out));
            compare("trap_done", 32'(idle), 32'(trap_done));
            compare("standby_mode", 32'(standby), 32'(standby_mode));
            compare("pth_done_flush", 32'(flush_all), 32'(pth_done_flush));
        end
    end

endmodule

/* tb_pipeline_control.sv */
`include "pipeline_cfg.svh"

module tb_pipeline_control;

    localparam int PHASE_LEN = 250;
    localparam int NUM_PHASES = 6;
    // reset, every phase and room for a trap to drain after each one
    localparam int TIMEOUT = (8 + NUM_PHASES * (PHASE_LEN + 40)) * 20;

    logic                      clk, reset, csr_ready, ex_jump, branch_miss;
    logic                      mem_reg_we, mem_csr_we, wb_reg_we, wb_csr_we;
    logic                      trap_valid, trap_ack;
    logic [`PIPE_REG_AW-1:0]   id_rs1, id_rs2, ex_rd, ex_rs1, ex_rs2, mem_rd, wb_rd;
    logic [`PIPE_CSR_AW-1:0]   ex_csr_addr, mem_csr_addr, wb_csr_addr;
    pipeline_pkg::opcode_e     ex_opcode;
    pipeline_pkg::trap_cause_e trap_cause, trap_cause_out;
    logic [`PIPE_XLEN-1:0]     rf_rs1_data, rf_rs2_data, csr_read_data, mem_alu_result;
    logic [`PIPE_XLEN-1:0]     wb_write_data, mem_csr_wdata, wb_csr_wdata;
    logic [`PIPE_XLEN-1:0]     ex_op1, ex_op2, ex_csr_op;
    logic [1:0]                hazard_mem, hazard_wb;
    logic                      csr_hazard_mem, csr_hazard_wb, trap_req, trap_done;
    logic                      standby_mode, pth_done_flush;
    logic                      if_id_flush, id_ex_flush, ex_mem_flush, mem_wb_flush;
    logic                      if_id_stall, id_ex_stall, ex_mem_stall, mem_wb_stall;
    int                        errors, checks;
    int unsigned               seed;

    pipeline_control uut (.*);
    hazard_checker chk (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic pipeline_pkg::opcode_e pick_opcode(input int unsigned n);
        pipeline_pkg::opcode_e op;
        case (n % 8)
            0: op = pipeline_pkg::OP_LOAD;
            1: op = pipeline_pkg::OP_STORE;
            2: op = pipeline_pkg::OP_BRANCH;
            3: op = pipeline_pkg::OP_JAL;
            4: op = pipeline_pkg::OP_JALR;
            5: op = pipeline_pkg::OP_OP;
            6: op = pipeline_pkg::OP_OP_IMM;
            default: op = pipeline_pkg::OP_SYSTEM;
        endcase
        return op;
    endfunction

    // mode 1 fwd, 2 load-use, 3 control, 4 csr, 5 trap, 6 standby
    task automatic set_inputs(input int mode);
        id_rs1 = `PIPE_REG_AW'($urandom % 4); // x0..x3 so matches are common
        id_rs2 = `PIPE_REG_AW'($urandom % 4);
        ex_rd = `PIPE_REG_AW'($urandom % 4);
        ex_rs1 = `PIPE_REG_AW'($urandom % 4);
        ex_rs2 = `PIPE_REG_AW'($urandom % 4);
        mem_rd = `PIPE_REG_AW'($urandom % 4);
        wb_rd = `PIPE_REG_AW'($urandom % 4);
        ex_opcode = (mode == 2 && ($urandom % 2 == 0)) ? pipeline_pkg::OP_LOAD
                                                      : pick_opcode($urandom);
        ex_csr_addr = `PIPE_CSR_AW'(32'h300 + $urandom % 4);
        mem_csr_addr = `PIPE_CSR_AW'(32'h300 + $urandom % 4);
        wb_csr_addr = `PIPE_CSR_AW'(32'h300 + $urandom % 4);
        mem_reg_we = ($urandom % 2 == 0);
        wb_reg_we = ($urandom % 2 == 0);
        mem_csr_we = ($urandom % 2 == 0);
        wb_csr_we = ($urandom % 2 == 0);
        ex_jump = ($urandom % ((mode == 3) ? 3 : 8) == 0);
        branch_miss = ($urandom % ((mode == 3) ? 3 : 8) == 0);
        csr_ready = (mode == 4 || mode == 6) ? ($urandom % 2 == 0) : 1'b1;
        rf_rs1_data = $urandom;
        rf_rs2_data = $urandom;
        csr_read_data = $urandom;
        mem_alu_result = $urandom;
        wb_write_data = $urandom;
        mem_csr_wdata = $urandom;
        wb_csr_wdata = $urandom;
        trap_valid = (mode == 3) ? ($urandom % 16 == 0) :
                     (mode >= 5) ? ($urandom % 4 == 0) : 1'b0;
        trap_cause = (mode == 6) ? pipeline_pkg::TRAP_ID_EXCEPTION
                                 : pipeline_pkg::trap_cause_e'(3'(2 + $urandom % 3));
    endtask

    task automatic run_phase(input string name, input int mode);
        int err_start;
        int chk_start;
        err_start = errors;
        chk_start = checks;
        repeat (PHASE_LEN) begin
            @(negedge clk);
            set_inputs(mode);
        end
        @(negedge clk);
        trap_valid = 1'b0;
        while (!trap_done) begin
            @(negedge clk); // handler still busy
        end
        @(negedge clk);
        $display("%-10s %0d checks, %0d errors", name, checks - chk_start, errors - err_start);
    endtask

    // trap handler answers each handshake edge after 0..5 cycles
    initial begin
        int unsigned wait_cycles;
        trap_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (trap_req != trap_ack) begin
                wait_cycles = $urandom % 6;
                repeat (wait_cycles) @(negedge clk);
                trap_ack = !trap_ack;
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: run still going after %0d time units", TIMEOUT);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed = 32'hf071c301;
        void'($urandom(seed));
        reset = 1'b1;
        set_inputs(0);
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_phase("forwarding", 1);
        run_phase("load_use", 2);
        run_phase("ctrl_flush", 3);
        run_phase("csr", 4);
        run_phase("trap", 5);
        run_phase("standby", 6);
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
pipeline_pkg.sv
hazard_unit.sv
forward_unit.sv
trap_sequencer.sv
pipeline_control.sv
hazard_checker.sv
tb_pipeline_control.sv

/* Bender.yml */
package:
  name: pipeline_control

sources:
  - include_dirs:
      - .
    files:
      - pipeline_pkg.sv
      - hazard_unit.sv
      - forward_unit.sv
      - trap_sequencer.sv
      - pipeline_control.sv
  - target: test
    include_dirs:
      - .
    files:
      - hazard_checker.sv
      - tb_pipeline_control.sv
